// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= icache_tb
LINT_TOP  ?= icache_top
FILELIST  ?= icache_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(wildcard design/*.sv bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/icache_patterns.txt ====
# op address expected: op F is a fetch, op I an invalidate with its address unused
# expected is the first-try outcome of a fetch, H for hit and M for miss, and - for I
F 00001040 M
F 00001040 H
F 00001050 H
F 00001064 H
F 00001078 H
F 00002080 M
F 000020b0 H
F 000050c0 M
F 00003040 M
F 00003050 H
F 000050c8 H
F 000020a0 H
F 8000f100 M
F 00000fc0 M
F 8000f130 H
F 00000ff0 H
F 000050d0 H
I 00000000 -
F 000050c0 M
F 00003070 M
F 000050f0 H

// ==== bench/icache_tb.sv ====
// Must run from the project root to find its pattern file and assumes 64-byte lines of four beats
module icache_tb
  import icache_pkg::*;
();

  localparam int BLOCK_BYTES   = 64;                  // Four beats of 16 bytes
  localparam int BLOCK_SIZE    = 6;                   // Log2 of a block
  localparam int MAX_GROUP     = 4;                   // Longest back-to-back hit burst
  localparam int READY_TIMEOUT = 100;                 // Cycles
  localparam int RETRY_LIMIT   = 4;
  localparam int MAX_LINES     = 256;

  logic        clock;
  logic        reset;
  logic        req_valid;
  fetch_req_t  req;
  logic        req_ready;
  logic        resp_valid;
  fetch_resp_t resp;
  logic        mem_a_valid;
  mem_get_t    mem_a;
  logic        mem_a_ready;
  logic        mem_d_valid;
  mem_beat_t   mem_d;
  logic        invalidate;

  byte                   pat_op [$];                  // F or I
  logic [ADDR_BITS-1:0]  pat_addr [$];
  bit                    pat_hit [$];                 // Expected first try
  int                    cycle_count;
  int                    resp_cycles [$];             // Negedge count of each response
  logic [FETCH_BITS-1:0] resp_words [$];
  bit                    got_hit [MAX_GROUP];
  logic [31:0]           rng_state;
  mem_get_t              held_get;                    // Get seen while ready is low
  mem_get_t              last_get;
  bit                    get_held;
  int                    ready_delay;
  int                    beats_left;
  int                    beat_gap;
  logic [ADDR_BITS-1:0]  beat_addr;
  int                    get_count;
  bit                    refill_open;                 // From Get until last beat lands
  bit                    last_beat_sent;
  int                    mismatch_count;
  int                    failure_count;

  icache_top #(.NUM_SETS(64), .NUM_WAYS(2), .LINE_BEATS(4)) icache_top_inst (
    .clock       (clock),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .mem_a_valid (mem_a_valid),
    .mem_a       (mem_a),
    .mem_a_ready (mem_a_ready),
    .mem_d_valid (mem_d_valid),
    .mem_d       (mem_d),
    .invalidate  (invalidate)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {16'h0000, rng_state[31:16]};              // Upper half is the better half
  endfunction

  // Each 32-bit lane holds its own byte address
  function automatic logic [FETCH_BITS-1:0] lane_word(input logic [ADDR_BITS-1:0] addr);
    logic [ADDR_BITS-1:0]  base;
    logic [FETCH_BITS-1:0] word;
    base = {addr[ADDR_BITS-1:4], 4'h0};
    for (int i = 0; i < 4; i++) begin
      word[32*i +: 32] = base + 32'(4 * i);
    end
    return word;
  endfunction

  task automatic report_mismatch(input string msg);
    mismatch_count++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    failure_count++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // Drives the memory side once per falling edge
  task automatic drive_memory();
    mem_a_ready = 1'b0;
    mem_d_valid = 1'b0;
    if (beats_left > 0) begin
      if (beat_gap > 0) begin
        beat_gap--;                                   // Idle cycle between beats
      end else begin
        mem_d_valid  = 1'b1;
        mem_d.opcode = access_ack_data;
        mem_d.size   = 4'(BLOCK_SIZE);
        mem_d.data   = lane_word(beat_addr);
        beat_addr    = beat_addr + 32'd16;
        beats_left--;
        beat_gap     = int'(next_rand() % 4);
        last_beat_sent = (beats_left == 0);
      end
    end else if (mem_a_valid) begin
      if (!get_held) begin
        held_get    = mem_a;
        get_held    = 1'b1;
        ready_delay = int'(next_rand() % 4);          // Back-pressure length
      end
      assert (mem_a == held_get) else report_mismatch($sformatf(
        "mem_a moved from %h to %h while held", held_get, mem_a));
      if (ready_delay > 0) begin
        ready_delay--;
      end else begin
        mem_a_ready = 1'b1;                           // Fires at next rising edge
        get_held    = 1'b0;
        get_count++;
        last_get    = mem_a;
        beats_left  = 4;
        beat_addr   = mem_a.address;
        beat_gap    = int'(next_rand() % 4);
      end
    end
  endtask

  task automatic step_cycle();
    @(negedge clock);
    cycle_count++;
    if (resp_valid) begin
      resp_cycles.push_back(cycle_count);
      resp_words.push_back(resp.data);
    end
    if (last_beat_sent) begin
      assert (req_ready) else report_mismatch("req_ready still low after the last beat");
      refill_open    = 1'b0;
      last_beat_sent = 1'b0;
    end
    if (mem_a_valid) begin
      refill_open = 1'b1;
    end
    if (refill_open) begin
      assert (!req_ready) else report_mismatch("req_ready high during a refill");
    end
    drive_memory();
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!req_ready && waited < READY_TIMEOUT) begin
      step_cycle();
      waited++;
    end
    if (!req_ready) begin
      report_failure("timed out waiting for req_ready to return");
    end
  endtask

  // Issues fetches on consecutive cycles and matches each response to its slot
  task automatic issue_group(input int first, input int count);
    int                   issued [MAX_GROUP];
    int                   found;
    logic [ADDR_BITS-1:0] addr;
    wait_ready();
    resp_cycles.delete();
    resp_words.delete();
    for (int i = 0; i < count; i++) begin
      got_hit[i] = 1'b0;
      issued[i]  = req_ready ? cycle_count : -100;   // Closed cache takes nothing
      req_valid  = req_ready;
      req.addr   = pat_addr[first + i];
      step_cycle();
    end
    req_valid = 1'b0;
    step_cycle();
    step_cycle();
    found = 0;
    for (int i = 0; i < count; i++) begin
      addr = pat_addr[first + i];
      for (int j = 0; j < resp_cycles.size(); j++) begin
        if (resp_cycles[j] == issued[i] + 2) begin    // Hit latency is two cycles
          got_hit[i] = 1'b1;
          found++;
          assert (resp_words[j] == lane_word(addr)) else report_mismatch($sformatf(
            "fetch %h returned %h, expected %h", addr, resp_words[j], lane_word(addr)));
        end
      end
    end
    assert (found == resp_cycles.size()) else report_mismatch($sformatf(
      "%0d responses seen, %0d belong to a request", resp_cycles.size(), found));
    if (found < count) begin
      if (count == 1) begin                           // One cycle past the s2 miss
        assert (mem_a_valid && !req_ready) else report_mismatch(
          "Get not raised with req_ready low in the cycle after the miss");
      end
    end
  endtask

  task automatic run_group(input int first, input int count);
    bit                   first_try [MAX_GROUP];
    bit                   done;
    int                   gets_before;
    int                   expected_gets;
    int                   attempts;
    logic [ADDR_BITS-1:0] addr;
    gets_before   = get_count;
    expected_gets = 0;
    issue_group(first, count);
    for (int i = 0; i < count; i++) begin
      first_try[i] = got_hit[i];
      if (!pat_hit[first + i]) begin
        expected_gets++;
      end
      assert (got_hit[i] == pat_hit[first + i]) else report_mismatch($sformatf(
        "fetch %h first try hit=%0b, expected %0b", pat_addr[first + i], got_hit[i],
        pat_hit[first + i]));
    end
    for (int i = 0; i < count; i++) begin
      done     = first_try[i];
      attempts = 0;
      while (!done && attempts < RETRY_LIMIT) begin
        issue_group(first + i, 1);
        done = got_hit[0];
        attempts++;
      end
      if (!done) begin
        report_failure($sformatf("fetch %h never hit after %0d retries",
          pat_addr[first + i], attempts));
      end else if (!first_try[i]) begin
        assert (attempts == 1) else report_mismatch($sformatf(
          "fetch %h needed %0d retries after its refill", pat_addr[first + i], attempts));
      end
    end
    assert (get_count - gets_before == expected_gets) else report_mismatch($sformatf(
      "%0d Gets for fetch %h, expected %0d", get_count - gets_before, pat_addr[first],
      expected_gets));
    if (count == 1 && !pat_hit[first]) begin
      addr = pat_addr[first];
      assert (last_get.address == (addr & ~32'(BLOCK_BYTES - 1)) &&
              last_get.size == 4'(BLOCK_SIZE)) else report_mismatch($sformatf(
        "Get %h size %0d for fetch %h", last_get.address, last_get.size, addr));
    end
  endtask

  task automatic send_invalidate();
    invalidate = 1'b1;
    step_cycle();
    invalidate = 1'b0;
  endtask

  task automatic load_patterns();
    int                   fd;
    int                   lines;
    int                   fields;
    string                line;
    byte                  op;
    byte                  outcome;
    logic [ADDR_BITS-1:0] addr;
    fd = $fopen("bench/icache_patterns.txt", "r");
    if (fd == 0) begin
      report_failure("could not open bench/icache_patterns.txt");
      return;
    end
    lines = 0;
    while (!$feof(fd) && lines < MAX_LINES) begin
      line   = "";
      fields = $fgets(line, fd);
      if (fields > 0 && line.len() > 1 && line[0] != "#") begin
        fields = $sscanf(line, "%c %h %c", op, addr, outcome);
        if (fields == 3) begin
          pat_op.push_back(op);
          pat_addr.push_back(addr);
          pat_hit.push_back(outcome == "H");
        end else begin
          report_failure($sformatf("pattern line not understood: %s", line));
        end
      end
      lines++;
    end
    $fclose(fd);
  endtask

  initial begin
    int i;
    int n;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    mem_a_ready = 1'b0;
    mem_d_valid = 1'b0;
    mem_d       = '0;
    invalidate  = 1'b0;
    rng_state   = 32'h682a_54ae;
    cycle_count = 0;
    get_held    = 1'b0;
    ready_delay = 0;
    beats_left  = 0;
    beat_gap    = 0;
    beat_addr   = '0;
    get_count   = 0;
    held_get    = '0;
    last_get    = '0;
    refill_open = 1'b0;
    last_beat_sent = 1'b0;
    mismatch_count = 0;
    failure_count  = 0;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    assert (req_ready && !resp_valid && !mem_a_valid) else report_mismatch(
      "req_ready, resp_valid or mem_a_valid wrong after reset");
    load_patterns();
    i = 0;
    while (i < pat_op.size()) begin
      n = 1;
      if (pat_op[i] == "I") begin
        send_invalidate();
      end else begin
        while (pat_hit[i] && n < MAX_GROUP && i + n < pat_op.size() &&
               pat_op[i + n] == "F" && pat_hit[i + n]) begin
          n++;                                        // Gather a hit burst
        end
        run_group(i, n);
      end
      i += n;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0 && pat_op.size() > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== design/beat_counter.sv ====
// Outputs are valid only while a beat is on the response channel and follow its size field
module beat_counter import icache_pkg::*; #(
  parameter int LINE_BEATS = 4
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          mem_d_valid,
  input  mem_beat_t                     mem_d,
  output logic [$clog2(LINE_BEATS)-1:0] beat_index,
  output logic                          beat_last
);

  localparam int WORD_BITS  = $clog2(FETCH_BYTES);
  localparam int BEAT_BITS  = $clog2(LINE_BEATS);
  localparam int COUNT_BITS = 8;
  localparam int MASK_BITS  = COUNT_BITS + WORD_BITS;

  logic                  has_data;
  logic [MASK_BITS-1:0]  size_mask;
  logic [COUNT_BITS-1:0] beats_m1;    // Beats in burst minus one
  logic [COUNT_BITS-1:0] count;       // Beats left, zero between bursts
  logic [COUNT_BITS-1:0] count_m1;
  logic [COUNT_BITS-1:0] index_full;
  logic                  first;

  always_comb begin
    has_data   = mem_d.opcode[0];
    size_mask  = ~({MASK_BITS{1'b1}} << mem_d.size); // Bytes minus one
    beats_m1   = has_data ? size_mask[MASK_BITS-1:WORD_BITS] : '0;
    count_m1   = count - 1'b1;
    first      = (count == '0);
    beat_last  = (count == COUNT_BITS'(1)) || (beats_m1 == '0);
    index_full = beats_m1 & ~count_m1;                // Zero on first beat
    beat_index = index_full[BEAT_BITS-1:0];
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (mem_d_valid) begin
      if (first) begin
        count <= beats_m1;                            // Load at burst start
      end else begin
        count <= count_m1;
      end
    end
  end

endmodule

// ==== design/fetch_pipeline.sv ====
// A miss drops itself and both younger requests without a response so the fetch side must retry
module fetch_pipeline import icache_pkg::*; #(
  parameter int NUM_SETS   = 64,
  parameter int NUM_WAYS   = 2,
  parameter int LINE_BEATS = 4
) (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic                                                req_valid,
  input  fetch_req_t                                          req,
  output logic                                                req_ready,
  output logic                                                resp_valid,
  output fetch_resp_t                                         resp,
  input  logic                                                refill_busy,
  output logic                                                rd_en,
  output logic [$clog2(NUM_SETS)+$clog2(LINE_BEATS)-1:0]      rd_index,
  input  logic [NUM_WAYS-1:0]
               [ADDR_BITS-$clog2(NUM_SETS)-$clog2(LINE_BEATS*FETCH_BYTES)-1:0] way_tags,
  input  logic [NUM_WAYS-1:0]                                 way_valid,
  input  logic [NUM_WAYS-1:0][FETCH_BITS-1:0]                 way_words,
  output logic                                                miss,
  output logic [ADDR_BITS-1:0]                                miss_addr
);

  localparam int OFFSET_BITS = $clog2(LINE_BEATS * FETCH_BYTES);
  localparam int WORD_BITS   = $clog2(FETCH_BYTES);
  localparam int INDEX_BITS  = $clog2(NUM_SETS);
  localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

  logic                                fire;
  logic                                s1_valid;
  logic [ADDR_BITS-1:0]                s1_addr;
  logic [NUM_WAYS-1:0]                 s1_hit;     // One-hot tag match
  logic                                s2_valid;
  logic [ADDR_BITS-1:0]                s2_addr;
  logic [NUM_WAYS-1:0]                 s2_hit;
  logic [NUM_WAYS-1:0][FETCH_BITS-1:0] s2_words;
  logic [FETCH_BITS-1:0]               word_sel;

  always_comb begin
    req_ready = !refill_busy;                         // Closed for the whole refill
    fire      = req_valid && req_ready;
    rd_en     = fire;                                 // s0 array read
    rd_index  = req.addr[OFFSET_BITS+INDEX_BITS-1:WORD_BITS];
    for (int w = 0; w < NUM_WAYS; w++) begin
      s1_hit[w] = way_valid[w] && (way_tags[w] == s1_addr[ADDR_BITS-1 -: TAG_BITS]);
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s2_hit   <= '0;
    end else begin
      s1_valid <= fire && !miss;                      // Squash s0 on miss
      s2_valid <= s1_valid && !miss;                  // Squash s1 on miss
      s2_hit   <= s1_hit;
    end
  end

  // Address and data ride along with the valids
  always_ff @(posedge clock) begin
    if (fire) begin
      s1_addr <= req.addr;
    end
    s2_addr  <= s1_addr;
    s2_words <= way_words;                            // Arrays answer in s1
  end

  always_comb begin
    word_sel = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (s2_hit[w]) begin
        word_sel = word_sel | s2_words[w];
      end
    end
    resp_valid = s2_valid && (|s2_hit);
    resp.data  = word_sel;
    miss       = s2_valid && !(|s2_hit);              // Single cycle, s2 empties next
    miss_addr  = s2_addr;
  end

endmodule

// ==== design/icache_pkg.sv ====
// Widths and bus encodings assume 32-bit addresses and 128-bit fetch words and beats
package icache_pkg;

  localparam int ADDR_BITS   = 32;  // Fetch and memory address
  localparam int FETCH_BITS  = 128; // One fetch word, one memory beat
  localparam int FETCH_BYTES = 16;

  // Low bit set means the beat carries data
  typedef enum logic [2:0] {
    access_ack      = 3'd0,
    access_ack_data = 3'd1
  } mem_opcode_e;

  typedef enum logic [1:0] {
    idle,
    request,     // Get held on the A channel
    wait_data    // Collecting response beats
  } refill_state_e;

  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [FETCH_BITS-1:0] data;
  } fetch_resp_t;

  typedef struct packed {
    logic [ADDR_BITS-1:0] address; // Block aligned
    logic [3:0]           size;    // Log2 of bytes
  } mem_get_t;

  typedef struct packed {
    mem_opcode_e           opcode;
    logic [3:0]            size;   // Log2 of whole transfer
    logic [FETCH_BITS-1:0] data;
  } mem_beat_t;

endpackage

// ==== design/icache_top.sv ====
// Responses have no back-pressure and the memory response channel is always accepted
module icache_top import icache_pkg::*; #(
  parameter int NUM_SETS   = 64,
  parameter int NUM_WAYS   = 2,
  parameter int LINE_BEATS = 4
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  input  fetch_req_t  req,
  output logic        req_ready,
  output logic        resp_valid,
  output fetch_resp_t resp,
  output logic        mem_a_valid,
  output mem_get_t    mem_a,
  input  logic        mem_a_ready,
  input  logic        mem_d_valid,
  input  mem_beat_t   mem_d,
  input  logic        invalidate
);

  localparam int OFFSET_BITS = $clog2(LINE_BEATS * FETCH_BYTES);
  localparam int INDEX_BITS  = $clog2(NUM_SETS);
  localparam int BEAT_BITS   = $clog2(LINE_BEATS);
  localparam int ROW_BITS    = INDEX_BITS + BEAT_BITS;
  localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int WAY_BITS    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  logic                                 rd_en;
  logic [ROW_BITS-1:0]                  rd_index;   // Set plus word offset
  logic [NUM_WAYS-1:0][TAG_BITS-1:0]    way_tags;
  logic [NUM_WAYS-1:0]                  way_valid;
  logic [NUM_WAYS-1:0][FETCH_BITS-1:0]  way_words;
  logic                                 miss;
  logic [ADDR_BITS-1:0]                 miss_addr;
  logic                                 refill_busy;
  logic                                 tag_wr_en;
  logic                                 data_wr_en;
  logic [WAY_BITS-1:0]                  wr_way;     // Victim
  logic [INDEX_BITS-1:0]                wr_index;
  logic [TAG_BITS-1:0]                  wr_tag;
  logic [BEAT_BITS-1:0]                 beat_index;
  logic                                 beat_last;

  fetch_pipeline #(
    .NUM_SETS   (NUM_SETS),
    .NUM_WAYS   (NUM_WAYS),
    .LINE_BEATS (LINE_BEATS)
  ) u_pipe (
    .clock       (clock),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .refill_busy (refill_busy),
    .rd_en       (rd_en),
    .rd_index    (rd_index),
    .way_tags    (way_tags),
    .way_valid   (way_valid),
    .way_words   (way_words),
    .miss        (miss),
    .miss_addr   (miss_addr)
  );

  tag_valid_store #(
    .NUM_SETS   (NUM_SETS),
    .NUM_WAYS   (NUM_WAYS),
    .LINE_BEATS (LINE_BEATS)
  ) u_tags (
    .clock      (clock),
    .reset      (reset),
    .rd_en      (rd_en),
    .rd_index   (rd_index),
    .way_tags   (way_tags),
    .way_valid  (way_valid),
    .wr_en      (tag_wr_en),
    .wr_way     (wr_way),
    .wr_index   (wr_index),
    .wr_tag     (wr_tag),
    .invalidate (invalidate)
  );

  line_data_store #(
    .NUM_SETS   (NUM_SETS),
    .NUM_WAYS   (NUM_WAYS),
    .LINE_BEATS (LINE_BEATS)
  ) u_data (
    .clock     (clock),
    .rd_en     (rd_en),
    .rd_index  (rd_index),
    .way_words (way_words),
    .wr_en     (data_wr_en),
    .wr_way    (wr_way),
    .wr_index  (wr_index),
    .wr_beat   (beat_index),
    .wr_data   (mem_d.data)
  );

  refill_ctrl #(
    .NUM_SETS   (NUM_SETS),
    .NUM_WAYS   (NUM_WAYS),
    .LINE_BEATS (LINE_BEATS)
  ) u_refill (
    .clock       (clock),
    .reset       (reset),
    .miss        (miss),
    .miss_addr   (miss_addr),
    .invalidate  (invalidate),
    .mem_a_valid (mem_a_valid),
    .mem_a       (mem_a),
    .mem_a_ready (mem_a_ready),
    .mem_d_valid (mem_d_valid),
    .mem_d       (mem_d),
    .beat_last   (beat_last),
    .refill_busy (refill_busy),
    .tag_wr_en   (tag_wr_en),
    .data_wr_en  (data_wr_en),
    .wr_way      (wr_way),
    .wr_index    (wr_index),
    .wr_tag      (wr_tag)
  );

  beat_counter #(
    .LINE_BEATS (LINE_BEATS)
  ) u_beats (
    .clock       (clock),
    .reset       (reset),
    .mem_d_valid (mem_d_valid),
    .mem_d       (mem_d),
    .beat_index  (beat_index),
    .beat_last   (beat_last)
  );

endmodule

// ==== design/line_data_store.sv ====
// Reads return one full fetch word a cycle after rd_en and contents are undefined until refilled
module line_data_store import icache_pkg::*; #(
  parameter int NUM_SETS   = 64,
  parameter int NUM_WAYS   = 2,
  parameter int LINE_BEATS = 4
) (
  input  logic                                               clock,
  input  logic                                               rd_en,
  input  logic [$clog2(NUM_SETS)+$clog2(LINE_BEATS)-1:0]     rd_index,
  output logic [NUM_WAYS-1:0][FETCH_BITS-1:0]                way_words,
  input  logic                                               wr_en,
  input  logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] wr_way,
  input  logic [$clog2(NUM_SETS)-1:0]                        wr_index,
  input  logic [$clog2(LINE_BEATS)-1:0]                      wr_beat,
  input  logic [FETCH_BITS-1:0]                              wr_data
);

  localparam int ROWS = NUM_SETS * LINE_BEATS;        // One row per beat

  logic [FETCH_BITS-1:0] data_mem [NUM_WAYS][ROWS];

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[wr_way][{wr_index, wr_beat}] <= wr_data; // Beat lands in its row
    end
    if (rd_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        way_words[w] <= data_mem[w][rd_index];
      end
    end
  end

endmodule

// ==== design/refill_ctrl.sv ====
// One refill at a time and a refill hit by an invalidate leaves its line invalid
module refill_ctrl import icache_pkg::*; #(
  parameter int NUM_SETS   = 64,
  parameter int NUM_WAYS   = 2,
  parameter int LINE_BEATS = 4
) (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic                                               miss,
  input  logic [ADDR_BITS-1:0]                               miss_addr,
  input  logic                                               invalidate,
  output logic                                               mem_a_valid,
  output mem_get_t                                           mem_a,
  input  logic                                               mem_a_ready,
  input  logic                                               mem_d_valid,
  input  mem_beat_t                                          mem_d,
  input  logic                                               beat_last,
  output logic                                               refill_busy,
  output logic                                               tag_wr_en,
  output logic                                               data_wr_en,
  output logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] wr_way,
  output logic [$clog2(NUM_SETS)-1:0]                        wr_index,
  output logic [ADDR_BITS-$clog2(NUM_SETS)-$clog2(LINE_BEATS*FETCH_BYTES)-1:0] wr_tag
);

  localparam int OFFSET_BITS = $clog2(LINE_BEATS * FETCH_BYTES);
  localparam int INDEX_BITS  = $clog2(NUM_SETS);
  localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int WAY_BITS    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  refill_state_e        state;
  logic [ADDR_BITS-1:0] refill_addr;
  logic [15:0]          lfsr;          // Victim source
  logic                 invalidated;
  logic                 a_fire;
  logic                 data_beat;

  always_comb begin
    mem_a_valid   = (state == request);
    a_fire        = mem_a_valid && mem_a_ready;
    mem_a.address = {refill_addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    mem_a.size    = 4'(OFFSET_BITS);                  // Whole block
    refill_busy   = (state != idle);
    data_beat     = (state == wait_data) && mem_d_valid && mem_d.opcode[0];
    data_wr_en    = data_beat && !invalidated;
    tag_wr_en     = data_wr_en && beat_last;          // Line valid only once complete
    wr_way        = lfsr[WAY_BITS-1:0];
    wr_index      = refill_addr[OFFSET_BITS +: INDEX_BITS];
    wr_tag        = refill_addr[ADDR_BITS-1 -: TAG_BITS];
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state       <= idle;
      lfsr        <= 16'h0001;                        // Any nonzero seed
      invalidated <= 1'b0;
    end else begin
      case (state)
        idle:      if (miss) state <= request;
        request:   if (a_fire) state <= wait_data;
        wait_data: if (data_beat && beat_last) state <= idle;
        default:   state <= idle;
      endcase
      if (a_fire) begin
        lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]}; // x^16+x^15+x^13+x^4+1
      end
      if (state == idle) begin
        invalidated <= 1'b0;
      end else if (invalidate) begin
        invalidated <= 1'b1;                          // Sticky until refill ends
      end
    end
  end

  // Miss address captured once and held through the refill
  always_ff @(posedge clock) begin
    if (state == idle && miss) begin
      refill_addr <= miss_addr;
    end
  end

endmodule

// ==== design/tag_valid_store.sv ====
// Read data lags rd_en by one cycle and an invalidate beats a tag write in the same cycle
module tag_valid_store import icache_pkg::*; #(
  parameter int NUM_SETS   = 64,
  parameter int NUM_WAYS   = 2,
  parameter int LINE_BEATS = 4
) (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic                                               rd_en,
  input  logic [$clog2(NUM_SETS)+$clog2(LINE_BEATS)-1:0]     rd_index,
  output logic [NUM_WAYS-1:0]
               [ADDR_BITS-$clog2(NUM_SETS)-$clog2(LINE_BEATS*FETCH_BYTES)-1:0] way_tags,
  output logic [NUM_WAYS-1:0]                                way_valid,
  input  logic                                               wr_en,
  input  logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] wr_way,
  input  logic [$clog2(NUM_SETS)-1:0]                        wr_index,
  input  logic [ADDR_BITS-$clog2(NUM_SETS)-$clog2(LINE_BEATS*FETCH_BYTES)-1:0] wr_tag,
  input  logic                                               invalidate
);

  localparam int BEAT_BITS  = $clog2(LINE_BEATS);
  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - $clog2(LINE_BEATS * FETCH_BYTES);

  logic [TAG_BITS-1:0]               tag_mem [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_bits;
  logic [INDEX_BITS-1:0]             rd_set;

  assign rd_set = rd_index[INDEX_BITS+BEAT_BITS-1:BEAT_BITS]; // Drop word offset

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_mem[wr_way][wr_index] <= wr_tag;
    end
    if (rd_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        way_tags[w] <= tag_mem[w][rd_set];
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      valid_bits <= '0;
      way_valid  <= '0;
    end else begin
      if (invalidate) begin
        valid_bits <= '0;                             // Flash clear
      end else if (wr_en) begin
        valid_bits[wr_way][wr_index] <= 1'b1;
      end
      if (rd_en) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          way_valid[w] <= valid_bits[w][rd_set];
        end
      end
    end
  end

endmodule

// ==== icache_top.f ====
design/icache_pkg.sv
design/beat_counter.sv
design/line_data_store.sv
design/tag_valid_store.sv
design/refill_ctrl.sv
design/fetch_pipeline.sv
design/icache_top.sv
bench/icache_tb.sv
